/* include/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define WORD_W      32            // data and instruction width
`define REG_ADDR_W  5
`define NUM_REGS    32

// fetch address sequence
`define RESET_PC    32'h0000_0000
`define PC_STEP     32'd4

`endif

/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,       // r-type, decoded by funct
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a
    } funct_e;

    // instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS_MSB     = 25;
    localparam int RS_LSB     = 21;
    localparam int RT_MSB     = 20;
    localparam int RT_LSB     = 16;
    localparam int RD_MSB     = 15;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_MSB  = 10;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_MSB  = 5;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_MSB    = 15;
    localparam int IMM_LSB    = 0;

endpackage

/* verilog/mips_pipe_pkg.sv */
`include "mips_params.svh"

package mips_pipe_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation carried from decode into the alu
    typedef enum logic [3:0] {
        ALU_AND  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_NOR  = 4'd3,
        ALU_ADD  = 4'd4,          // wrapping, no overflow trap
        ALU_SUB  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SLT  = 4'd8,          // signed compare
        ALU_LUI  = 4'd9,
        ALU_NONE = 4'd10          // bubble or unknown encoding
    } alu_op_e;

endpackage

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module fetch_unit
    import mips_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t inst_o
);

    logic fetch_valid;            // rom_data_i answers last cycle's address

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rom_addr_o  <= `RESET_PC;
            rom_ce_o    <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            rom_ce_o    <= 1'b1;
            fetch_valid <= rom_ce_o;
            if (rom_ce_o) rom_addr_o <= rom_addr_o + `PC_STEP;
        end
    end

    // zero word is sll $0,$0,0 i.e. a no-op
    assign inst_o = fetch_valid ? rom_data_i : '0;

    // sequential fetch, no branches
    a_pc_step: assert property (@(posedge clk) disable iff (reset_i)
        rom_ce_o |=> rom_addr_o == $past(rom_addr_o) + `PC_STEP);

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module regfile
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[reg_addr_t'(i)] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // read with same-cycle bypass of the write port
    always_comb begin
        if (raddr1_i == '0) rdata1_o = '0;
        else if (we_i && waddr_i == raddr1_i) rdata1_o = wdata_i;
        else rdata1_o = regs[raddr1_i];

        if (raddr2_i == '0) rdata2_o = '0;
        else if (we_i && waddr_i == raddr2_i) rdata2_o = wdata_i;
        else rdata2_o = regs[raddr2_i];
    end

    // write enables arrive already filtered by decode
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        we_i |-> waddr_i != '0);

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module decode_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     inst_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    input  logic      ex_we_i,
    input  logic      mem_we_i,
    input  reg_addr_t ex_waddr_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     ex_wdata_i,
    input  word_t     mem_wdata_i,
    output alu_op_e   alu_op_o,
    output word_t     opnd1_o,
    output word_t     opnd2_o,
    output reg_addr_t waddr_o,
    output logic      we_o
);

    opcode_e     opcode;
    funct_e      funct;
    reg_addr_t   rs, rt, rd, waddr_d;
    logic [4:0]  shamt;
    logic [15:0] imm;
    alu_op_e     op_d;
    logic        use_rd, use_imm, sign_imm, is_shift, we_d;
    word_t       src1, src2, opnd2_d;

    assign opcode = opcode_e'(inst_i[OPCODE_MSB:OPCODE_LSB]);
    assign funct  = funct_e'(inst_i[FUNCT_MSB:FUNCT_LSB]);
    assign rs     = inst_i[RS_MSB:RS_LSB];
    assign rt     = inst_i[RT_MSB:RT_LSB];
    assign rd     = inst_i[RD_MSB:RD_LSB];
    assign shamt  = inst_i[SHAMT_MSB:SHAMT_LSB];
    assign imm    = inst_i[IMM_MSB:IMM_LSB];

    always_comb begin
        op_d     = ALU_NONE;
        use_rd   = 1'b0;
        use_imm  = 1'b1;
        sign_imm = 1'b0;
        is_shift = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_rd  = 1'b1;
                use_imm = 1'b0;
                case (funct)
                    F_AND:   op_d = ALU_AND;
                    F_OR:    op_d = ALU_OR;
                    F_XOR:   op_d = ALU_XOR;
                    F_NOR:   op_d = ALU_NOR;
                    F_ADDU:  op_d = ALU_ADD;
                    F_SUBU:  op_d = ALU_SUB;
                    F_SLT:   op_d = ALU_SLT;
                    F_SLL: begin op_d = ALU_SLL; is_shift = 1'b1; end
                    F_SRL: begin op_d = ALU_SRL; is_shift = 1'b1; end
                    default: op_d = ALU_NONE;
                endcase
            end
            OP_ANDI:  op_d = ALU_AND;
            OP_ORI:   op_d = ALU_OR;
            OP_XORI:  op_d = ALU_XOR;
            OP_LUI:   op_d = ALU_LUI;
            OP_ADDIU: begin op_d = ALU_ADD; sign_imm = 1'b1; end
            default:  op_d = ALU_NONE;
        endcase
    end

    assign waddr_d = use_rd ? rd : rt;
    assign we_d    = (op_d != ALU_NONE) && (waddr_d != '0); // $0 writes dropped here

    // shifts take rt as the value being shifted
    assign raddr1_o = is_shift ? rt : rs;
    assign raddr2_o = rt;

    // youngest producer wins, regfile covers write-back
    function automatic word_t fwd(input reg_addr_t addr, input word_t rf_data);
        word_t val;
        val = rf_data;
        if (ex_we_i && ex_waddr_i == addr) val = ex_wdata_i;
        else if (mem_we_i && mem_waddr_i == addr) val = mem_wdata_i;
        return val;
    endfunction

    always_comb begin
        src1 = fwd(raddr1_o, rdata1_i);
        src2 = fwd(raddr2_o, rdata2_i);
        if (is_shift) opnd2_d = word_t'(shamt);
        else if (!use_imm) opnd2_d = src2;
        else if (sign_imm) opnd2_d = {{(`WORD_W-16){imm[15]}}, imm};
        else opnd2_d = {{(`WORD_W-16){1'b0}}, imm};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            alu_op_o <= ALU_NONE;
            we_o     <= 1'b0;
        end else begin
            alu_op_o <= op_d;
            we_o     <= we_d;
        end
        opnd1_o <= src1;
        opnd2_o <= opnd2_d;
        waddr_o <= waddr_d;
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module execute_stage
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  alu_op_e   alu_op_i,
    input  word_t     opnd1_i,
    input  word_t     opnd2_i,
    input  reg_addr_t waddr_i,
    input  logic      we_i,
    output logic      ex_we_o,
    output reg_addr_t ex_waddr_o,
    output word_t     ex_wdata_o,
    output logic      mem_we_o,
    output reg_addr_t mem_waddr_o,
    output word_t     mem_wdata_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t alu_res;

    always_comb begin
        case (alu_op_i)
            ALU_AND: alu_res = opnd1_i & opnd2_i;
            ALU_OR:  alu_res = opnd1_i | opnd2_i;
            ALU_XOR: alu_res = opnd1_i ^ opnd2_i;
            ALU_NOR: alu_res = ~(opnd1_i | opnd2_i);
            ALU_ADD: alu_res = opnd1_i + opnd2_i;
            ALU_SUB: alu_res = opnd1_i - opnd2_i;
            ALU_SLL: alu_res = opnd1_i << opnd2_i[4:0];
            ALU_SRL: alu_res = opnd1_i >> opnd2_i[4:0]; // logical
            ALU_SLT: alu_res = word_t'($signed(opnd1_i) < $signed(opnd2_i));
            ALU_LUI: alu_res = {opnd2_i[15:0], {(`WORD_W-16){1'b0}}};
            default: alu_res = '0;
        endcase
    end

    // execute tap, seen by decode in the same cycle
    assign ex_we_o    = we_i;
    assign ex_waddr_o = waddr_i;
    assign ex_wdata_o = alu_res;

    // ex/mem and mem/wb
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_we_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else begin
            mem_we_o <= ex_we_o;
            wb_we_o  <= mem_we_o;
        end
        mem_waddr_o <= ex_waddr_o;
        mem_wdata_o <= ex_wdata_o;
        wb_addr_o   <= mem_waddr_o;
        wb_data_o   <= mem_wdata_o;
    end

    // decode drops $0 destinations, nothing here re-enables them
    a_wb_not_r0: assert property (@(posedge clk) disable iff (reset_i)
        wb_we_o |-> wb_addr_o != '0);

endmodule

/* verilog/mips_core.sv */
`timescale 1ns/1ps

module mips_core
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     rom_data_i,
    output word_t     rom_addr_o,
    output logic      rom_ce_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t     id_inst;
    reg_addr_t rf_raddr1, rf_raddr2;
    word_t     rf_rdata1, rf_rdata2;

    alu_op_e   ex_alu_op;
    word_t     ex_opnd1, ex_opnd2;
    reg_addr_t ex_waddr_in;
    logic      ex_we_in;

    // forwarding taps
    logic      ex_we, mem_we;
    reg_addr_t ex_waddr, mem_waddr;
    word_t     ex_wdata, mem_wdata;

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .inst_o     (id_inst)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (wb_we_o),     // write-back tap doubles as retire trace
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (id_inst),
        .raddr1_o    (rf_raddr1),
        .raddr2_o    (rf_raddr2),
        .rdata1_i    (rf_rdata1),
        .rdata2_i    (rf_rdata2),
        .ex_we_i     (ex_we),
        .mem_we_i    (mem_we),
        .ex_waddr_i  (ex_waddr),
        .mem_waddr_i (mem_waddr),
        .ex_wdata_i  (ex_wdata),
        .mem_wdata_i (mem_wdata),
        .alu_op_o    (ex_alu_op),
        .opnd1_o     (ex_opnd1),
        .opnd2_o     (ex_opnd2),
        .waddr_o     (ex_waddr_in),
        .we_o        (ex_we_in)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .alu_op_i    (ex_alu_op),
        .opnd1_i     (ex_opnd1),
        .opnd2_i     (ex_opnd2),
        .waddr_i     (ex_waddr_in),
        .we_i        (ex_we_in),
        .ex_we_o     (ex_we),
        .ex_waddr_o  (ex_waddr),
        .ex_wdata_o  (ex_wdata),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .wb_we_o     (wb_we_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

/* sim/retire_checker.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module retire_checker
    import mips_isa_pkg::*;
#(
    parameter int ITYPE_END    = 8,
    parameter int RTYPE_END    = 18,
    parameter int FWD_END      = 35,
    parameter int DIRECTED_END = 41
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   rom_ce_i,
    input  logic [`WORD_W-1:0]     rom_addr_i,
    input  logic [`WORD_W-1:0]     rom_data_i,
    input  logic                   wb_we_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`WORD_W-1:0]     wb_data_i,
    input  logic                   done_i,
    output logic                   reported_o,
    output int                     error_count_o
);

    localparam int WE_BIT = `REG_ADDR_W + `WORD_W;

    logic [`WORD_W-1:0]     model_regs [`NUM_REGS];
    // one entry per fetched word, program order
    logic                   q_we [$];
    logic [`REG_ADDR_W-1:0] q_addr [$];
    logic [`WORD_W-1:0]     q_data [$];
    logic [`WORD_W-1:0]     q_pc [$];
    int                     q_cycle [$];

    int                 cycle = 0;
    int                 errors = 0;
    int                 strobes = 0;
    int                 exp_writes = 0;
    logic               reported = 1'b0;
    logic               prev_ce = 1'b0;
    logic               ce_seen = 1'b0;
    logic [`WORD_W-1:0] prev_addr = '0;
    logic [`WORD_W-1:0] exp_addr = `RESET_PC;
    logic [WE_BIT:0]    res;

    assign reported_o    = reported;
    assign error_count_o = errors;

    // {we, dest, value} per the isa rules, against the model registers
    function automatic logic [WE_BIT:0] ref_exec(input logic [`WORD_W-1:0] inst);
        opcode_e                op;
        funct_e                 fn;
        logic [`REG_ADDR_W-1:0] rs, rt, rd, dest;
        logic [4:0]             shamt;
        logic [15:0]            imm;
        logic [`WORD_W-1:0]     a, b, val;
        logic                   we;
        op    = opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
        fn    = funct_e'(inst[FUNCT_MSB:FUNCT_LSB]);
        rs    = inst[RS_MSB:RS_LSB];
        rt    = inst[RT_MSB:RT_LSB];
        rd    = inst[RD_MSB:RD_LSB];
        shamt = inst[SHAMT_MSB:SHAMT_LSB];
        imm   = inst[IMM_MSB:IMM_LSB];
        a     = model_regs[rs];                      // model r0 stays zero
        b     = model_regs[rt];
        we    = 1'b1;
        dest  = rt;
        val   = '0;
        case (op)
            OP_SPECIAL: begin
                dest = rd;
                case (fn)
                    F_AND:   val = a & b;
                    F_OR:    val = a | b;
                    F_XOR:   val = a ^ b;
                    F_NOR:   val = ~(a | b);
                    F_ADDU:  val = a + b;
                    F_SUBU:  val = a - b;
                    F_SLL:   val = b << shamt;
                    F_SRL:   val = b >> shamt;
                    F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: we = 1'b0;
                endcase
            end
            OP_ANDI:  val = a & {16'h0000, imm};
            OP_ORI:   val = a | {16'h0000, imm};
            OP_XORI:  val = a ^ {16'h0000, imm};
            OP_LUI:   val = {imm, 16'h0000};
            OP_ADDIU: val = a + {{16{imm[15]}}, imm};
            default:  we = 1'b0;
        endcase
        if (dest == '0) we = 1'b0;
        return {we, dest, val};
    endfunction

    function automatic string test_name(input int idx);
        if (idx < ITYPE_END) return "itype";
        else if (idx < RTYPE_END) return "rtype";
        else if (idx < FWD_END) return "forward";
        else if (idx < DIRECTED_END) return "zero";
        return "random";
    endfunction

    task automatic drop_front();
        q_we.delete(0);
        q_addr.delete(0);
        q_data.delete(0);
        q_pc.delete(0);
        q_cycle.delete(0);
    endtask

    task automatic check_retire();
        strobes++;
        while (q_we.size() > 0 && !q_we[0]) begin
            drop_front();                            // no strobe expected for these
        end
        if (q_we.size() == 0) begin
            errors++;
            $display("unexpected retire strobe for r%0d in cycle %0d, nothing pending",
                     wb_addr_i, cycle);
        end else begin
            if (q_cycle[0] + 3 != cycle) begin
                errors++;
                $display("latency failure: pc %h retired in cycle %0d, expected cycle %0d",
                         q_pc[0], cycle, q_cycle[0] + 3);
            end
            if (wb_addr_i !== q_addr[0] || wb_data_i !== q_data[0]) begin
                errors++;
                $display("Mismatch %s: pc %h expected r%0d = %h, actual r%0d = %h",
                         test_name(int'(q_pc[0] >> 2)), q_pc[0], q_addr[0], q_data[0],
                         wb_addr_i, wb_data_i);
            end
            drop_front();
        end
    endtask

    task automatic final_report();
        int missing;
        missing = 0;
        foreach (q_we[i]) begin
            if (q_we[i]) missing++;
        end
        if (missing > 0) begin
            errors++;
            $display("%0d writing instructions never produced a retire strobe", missing);
        end else if (strobes != exp_writes) begin
            errors++;
            $display("saw %0d retire strobes but %0d writing instructions were fetched",
                     strobes, exp_writes);
        end
        $display("retire_checker: %0d strobes, %0d writes expected, %0d errors",
                 strobes, exp_writes, errors);
        reported = 1'b1;
    endtask

    // outputs settle after the rising edge, sample in the middle of the cycle
    always @(negedge clk) begin
        cycle++;
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                model_regs[5'(i)] = '0;
            end
            if (rom_ce_i !== 1'b0 || wb_we_i !== 1'b0) begin
                errors++;
                $display("rom enable or retire strobe not low during reset, cycle %0d", cycle);
            end
        end else begin
            if (prev_ce) begin
                res = ref_exec(rom_data_i);
                q_we.push_back(res[WE_BIT]);
                q_addr.push_back(res[WE_BIT-1:`WORD_W]);
                q_data.push_back(res[`WORD_W-1:0]);
                q_pc.push_back(prev_addr);
                q_cycle.push_back(cycle);
                if (res[WE_BIT]) begin
                    model_regs[res[WE_BIT-1:`WORD_W]] = res[`WORD_W-1:0];
                    exp_writes++;
                end
            end
            if (rom_ce_i === 1'b1) begin
                ce_seen = 1'b1;
                if (rom_addr_i !== exp_addr) begin
                    errors++;
                    $display("Mismatch fetch: expected %h, actual %h", exp_addr, rom_addr_i);
                end
                exp_addr = exp_addr + `PC_STEP;
            end else if (ce_seen) begin
                errors++;
                $display("rom enable dropped in cycle %0d after fetch started", cycle);
            end
            if (wb_we_i === 1'b1) begin
                check_retire();
            end else if (wb_we_i !== 1'b0) begin
                errors++;
                $display("retire strobe is unknown in cycle %0d", cycle);
            end
            if (done_i && !reported) final_report();
        end
        prev_ce   = !reset_i && rom_ce_i === 1'b1;
        prev_addr = rom_addr_i;
    end

endmodule

/* sim/tb_mips_core.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core
    import mips_isa_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DIRECTED_LEN = 41;
    localparam int RANDOM_LEN   = 200;
    localparam int PROG_LEN     = DIRECTED_LEN + RANDOM_LEN;
    localparam int TIMEOUT_NS   = (PROG_LEN + 20) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic [`WORD_W-1:0]     rom_data = '0;
    logic [`WORD_W-1:0]     rom_addr;
    logic                   rom_ce;
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`WORD_W-1:0]     wb_data;
    logic                   done = 1'b0;
    logic                   reported;
    int                     error_count;

    logic [`WORD_W-1:0]     prog [256];
    logic [31:0]            lfsr = 32'd1;
    int                     n_inst = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_core u_mips_core (
        .clk        (clk),
        .reset_i    (reset),
        .rom_data_i (rom_data),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .wb_we_o    (wb_we),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data)
    );

    retire_checker #(
        .ITYPE_END    (8),
        .RTYPE_END    (18),
        .FWD_END      (35),
        .DIRECTED_END (DIRECTED_LEN)
    ) u_retire_checker (
        .clk           (clk),
        .reset_i       (reset),
        .rom_ce_i      (rom_ce),
        .rom_addr_i    (rom_addr),
        .rom_data_i    (rom_data),
        .wb_we_i       (wb_we),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data),
        .done_i        (done),
        .reported_o    (reported),
        .error_count_o (error_count)
    );

    // synchronous rom, one cycle from address to word
    always @(posedge clk) begin
        if (rom_ce) begin
            if (rom_addr < 32'(PROG_LEN * 4)) rom_data <= prog[rom_addr[9:2]];
            else rom_data <= '0;                      // past the end reads as no-op
        end
    end

    function automatic logic [31:0] make_rtype(input logic [5:0] funct, input int rd,
                                               input int rs, input int rt, input int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic logic [31:0] make_itype(input logic [5:0] op, input int rt,
                                               input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // galois lfsr, x^32 + x^31 + x^29 + x + 1
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    function automatic logic [31:0] random_inst();
        int kind, rd, rs, rt, shamt, imm;
        kind  = rand_bits(4);
        rd    = rand_bits(3);                         // r0..r7 keeps hazards frequent
        rs    = rand_bits(3);
        rt    = rand_bits(3);
        shamt = rand_bits(5);
        imm   = rand_bits(16);
        case (kind)
            0:       return make_rtype(F_AND, rd, rs, rt, 0);
            1:       return make_rtype(F_OR, rd, rs, rt, 0);
            2:       return make_rtype(F_XOR, rd, rs, rt, 0);
            3:       return make_rtype(F_NOR, rd, rs, rt, 0);
            4:       return make_rtype(F_ADDU, rd, rs, rt, 0);
            5:       return make_rtype(F_SUBU, rd, rs, rt, 0);
            6:       return make_rtype(F_SLL, rd, 0, rt, shamt);
            7:       return make_rtype(F_SRL, rd, 0, rt, shamt);
            8:       return make_rtype(F_SLT, rd, rs, rt, 0);
            9:       return make_itype(OP_ANDI, rt, rs, imm);
            10:      return make_itype(OP_ORI, rt, rs, imm);
            11:      return make_itype(OP_XORI, rt, rs, imm);
            12:      return make_itype(OP_LUI, rt, 0, imm);
            13:      return make_itype(OP_ADDIU, rt, rs, imm);
            14:      return '0;
            default: return make_itype(6'h3f, rt, rs, imm);  // unsupported opcode
        endcase
    endfunction

    task automatic append(input logic [31:0] inst);
        prog[8'(n_inst)] = inst;
        n_inst++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            prog[8'(i)] = '0;
        end
        // i-type
        append(make_itype(OP_ORI, 1, 0, 'h1234));
        append(make_itype(OP_LUI, 2, 0, 'hdead));
        append(make_itype(OP_ORI, 2, 2, 'hbeef));
        append(make_itype(OP_ADDIU, 3, 0, -5));
        append(make_itype(OP_ANDI, 4, 2, 'hff0f));
        append(make_itype(OP_XORI, 5, 1, 'hffff));
        append(make_itype(OP_ADDIU, 6, 3, 100));
        append(make_itype(OP_ORI, 7, 0, 'h8000));
        // r-type, r3 is negative
        append(make_rtype(F_AND, 8, 2, 1, 0));
        append(make_rtype(F_OR, 9, 2, 3, 0));
        append(make_rtype(F_XOR, 10, 1, 5, 0));
        append(make_rtype(F_NOR, 11, 1, 3, 0));
        append(make_rtype(F_ADDU, 12, 3, 7, 0));
        append(make_rtype(F_SUBU, 13, 1, 2, 0));
        append(make_rtype(F_SLL, 14, 0, 2, 4));
        append(make_rtype(F_SRL, 15, 0, 3, 8));
        append(make_rtype(F_SLT, 16, 3, 1, 0));
        append(make_rtype(F_SLT, 17, 1, 3, 0));
        // producer to consumer at distance 1, 2, 3, 4
        append(make_itype(OP_ADDIU, 20, 0, 7));
        append(make_rtype(F_ADDU, 21, 20, 20, 0));
        append(make_itype(OP_ADDIU, 22, 0, 9));
        append('0);
        append(make_rtype(F_SUBU, 23, 22, 21, 0));
        append(make_itype(OP_LUI, 24, 0, 1));
        append('0);
        append('0);
        append(make_rtype(F_OR, 25, 24, 22, 0));
        append(make_itype(OP_XORI, 26, 0, 'h55));
        append('0);
        append('0);
        append('0);
        append(make_rtype(F_ADDU, 27, 26, 26, 0));
        append(make_itype(OP_ADDIU, 28, 0, 1));
        append(make_itype(OP_ADDIU, 28, 28, 2));   // ex and mem both hold r28
        append(make_itype(OP_ADDIU, 28, 28, 4));
        // writes to r0 and unknown encodings
        append(make_itype(OP_ADDIU, 0, 0, 5));
        append(make_rtype(F_OR, 0, 1, 2, 0));
        append(32'hffff_ffff);
        append(make_rtype(6'h08, 9, 1, 0, 0));
        append(make_rtype(F_ADDU, 29, 0, 0, 0));
        append(make_itype(OP_ORI, 30, 0, 'ha5a5));
        for (int i = 0; i < RANDOM_LEN; i++) begin
            append(random_inst());
        end
    endtask

    initial begin
        build_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (rom_addr < 32'(PROG_LEN * 4)) @(negedge clk);
        repeat (4) @(posedge clk);                   // last fetch reaches write-back
        done <= 1'b1;
        while (!reported) @(negedge clk);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mips_core.sv
sim/retire_checker.sv
sim/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build tb_mips_core with verilator, run it and scan the log for failures

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mips_core \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
